// ==== logic/csr_map_pkg.sv ====
/*
 * CSR address map, access request and write-operation types.
 * The core is RV64, so all register words are 64 bits wide.
 * misa is a constant, and writes to it are ignored.
 */
package csr_map_pkg;

    localparam int unsigned xlen   = 64;
    localparam int unsigned addr_w = 12;

    // Machine-mode register addresses
    // ------------------------------------------------------------
    localparam logic [addr_w-1:0] addr_mstatus  = 12'h300;
    localparam logic [addr_w-1:0] addr_misa     = 12'h301;
    localparam logic [addr_w-1:0] addr_mie      = 12'h304;
    localparam logic [addr_w-1:0] addr_mtvec    = 12'h305;
    localparam logic [addr_w-1:0] addr_mscratch = 12'h340;
    localparam logic [addr_w-1:0] addr_mepc     = 12'h341;
    localparam logic [addr_w-1:0] addr_mcause   = 12'h342;
    localparam logic [addr_w-1:0] addr_mtval    = 12'h343;
    localparam logic [addr_w-1:0] addr_mip      = 12'h344;

    localparam logic [xlen-1:0] misa_value = {2'b10, 62'h1104}; // MXL=64, M, I and C

    localparam logic [xlen-1:0] mtvec_base_reset = 64'h0000_0000_C000_0000;
    localparam logic [1:0]      mtvec_mode_reset = 2'b00;            // Direct mode
    localparam int unsigned     mtvec_vect_align = 128;              // Bytes, vectored mode

    typedef enum logic [1:0] {
        wr_write,
        wr_set,
        wr_clear
    } wr_kind_t;

    typedef struct packed {
        logic            en;                                          // Access valid this cycle
        logic            wr;                                          // Write, else read only
        wr_kind_t        kind;
        logic [addr_w-1:0] addr;
        logic [xlen-1:0] wdata;
    } csr_req_t;

    typedef struct packed {
        wr_kind_t        kind;
        logic [xlen-1:0] wdata;
    } wr_op_t;

    // Next register value for a write, set or clear
    function automatic logic [xlen-1:0] apply_op(input logic [xlen-1:0] old_val,
                                                 input wr_op_t op);
        logic [xlen-1:0] res;
        case (op.kind)
            wr_set:   res = old_val | op.wdata;
            wr_clear: res = old_val & ~op.wdata;
            default:  res = op.wdata;
        endcase
        return res;
    endfunction

endpackage

// ==== logic/csr_trap_pkg.sv ====
/*
 * Trap events and interrupt lines seen by the CSR block.
 * Only the listed synchronous causes may be written to mcause by software.
 */
package csr_trap_pkg;

    localparam int unsigned cause_w = 7;

    // Software-writable cause codes
    // ------------------------------------------------------------
    localparam logic [cause_w-1:0] cause_ialign   = 7'd0;
    localparam logic [cause_w-1:0] cause_iaccess  = 7'd1;
    localparam logic [cause_w-1:0] cause_iopcode  = 7'd2;
    localparam logic [cause_w-1:0] cause_breakpt  = 7'd3;
    localparam logic [cause_w-1:0] cause_ldalign  = 7'd4;
    localparam logic [cause_w-1:0] cause_ldaccess = 7'd5;
    localparam logic [cause_w-1:0] cause_stalign  = 7'd6;
    localparam logic [cause_w-1:0] cause_staccess = 7'd7;
    localparam logic [cause_w-1:0] cause_ecallm   = 7'd11;

    typedef struct packed {
        logic                           cpu;                          // Exception from the pipeline
        logic                           intr;                         // Interrupt taken
        logic [cause_w-1:0]             cause;
        logic [csr_map_pkg::xlen-1:0]   mtval;
        logic [csr_map_pkg::xlen-1:0]   pc;
    } trap_t;

    typedef struct packed {
        logic meip;                                                   // External
        logic mtip;                                                   // Timer
        logic msip;                                                   // Software
    } irq_lines_t;

endpackage

// ==== logic/csr_status_irq.sv ====
/*
 * mstatus MIE/MPIE plus the mie and mip registers.
 * All other mstatus fields read as zero and ignore writes.
 * A trap takes priority over MRET, and MRET over a software write.
 */
`timescale 1ns/1ps

module csr_status_irq
    import csr_map_pkg::*;
    import csr_trap_pkg::*;
(
    input  logic            g_clk,
    input  logic            g_resetn,
    input  logic            mstatus_we,
    input  logic            mie_we,
    input  wr_op_t          op,
    input  trap_t           trap,
    input  logic            exec_mret,
    input  irq_lines_t      irq_pend,
    output logic [xlen-1:0] mstatus_word,
    output logic [xlen-1:0] mie_word,
    output logic [xlen-1:0] mip_word,
    output logic            mstatus_mie,
    output irq_lines_t      irq_en
);

    // Places the three lines at bits 11, 7 and 3
    function automatic logic [xlen-1:0] irq_word(input irq_lines_t lines);
        logic [xlen-1:0] w;
        w     = '0;
        w[11] = lines.meip;
        w[7]  = lines.mtip;
        w[3]  = lines.msip;
        return w;
    endfunction

    logic            mie_q;
    logic            mpie_q;
    logic            trap_any;
    logic [xlen-1:0] mstatus_next;
    logic [xlen-1:0] mie_next;

    assign trap_any     = trap.cpu | trap.intr;
    assign mstatus_next = apply_op(mstatus_word, op);
    assign mie_next     = apply_op(mie_word, op);

    // Global enable and its saved copy
    // ------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mie_q  <= 1'b0;
            mpie_q <= 1'b0;
        end else if (trap_any) begin
            mie_q  <= 1'b0;
            mpie_q <= mie_q;                                          // Saved for MRET
        end else if (exec_mret) begin
            mie_q  <= mpie_q;
            mpie_q <= 1'b0;
        end else if (mstatus_we) begin
            mie_q  <= mstatus_next[3];
            mpie_q <= mstatus_next[7];
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            irq_en <= '0;
        end else if (mie_we) begin
            irq_en.meip <= mie_next[11];
            irq_en.mtip <= mie_next[7];
            irq_en.msip <= mie_next[3];
        end
    end

    always_comb begin
        mstatus_word    = '0;
        mstatus_word[3] = mie_q;
        mstatus_word[7] = mpie_q;
    end

    assign mie_word    = irq_word(irq_en);
    assign mip_word    = irq_word(irq_pend);                          // Live inputs, not stored
    assign mstatus_mie = mie_q;

endmodule

// ==== logic/csr_trap_record.sv ====
/*
 * Trap record registers mepc, mcause and mtval.
 * mepc bit 0 is always zero. mtval is only captured on CPU traps.
 * Software writes to mcause are dropped unless the result is a legal cause.
 */
`timescale 1ns/1ps

module csr_trap_record
    import csr_map_pkg::*;
    import csr_trap_pkg::*;
(
    input  logic            g_clk,
    input  logic            g_resetn,
    input  logic            mepc_we,
    input  logic            mcause_we,
    input  logic            mtval_we,
    input  wr_op_t          op,
    input  trap_t           trap,
    output logic [xlen-1:0] mepc_word,
    output logic [xlen-1:0] mcause_word,
    output logic [xlen-1:0] mtval_word,
    output logic [xlen-1:0] csr_mepc
);

    logic                trap_any;
    logic [xlen-1:1]     mepc_q;
    logic [xlen-1:1]     mepc_next;
    logic                mepc_load;
    logic                mcause_int_q;
    logic [cause_w-1:0]  mcause_code_q;
    logic [xlen-1:0]     mcause_next;
    logic                mcause_legal;
    logic [xlen-1:0]     mtval_q;
    logic [xlen-1:0]     sw_mepc;

    assign trap_any = trap.cpu | trap.intr;

    // mepc
    // ------------------------------------------------------------
    assign sw_mepc   = apply_op(mepc_word, op);
    assign mepc_next = trap_any ? trap.pc[xlen-1:1] : sw_mepc[xlen-1:1];
    assign mepc_load = trap_any | mepc_we;

    always_ff @(posedge g_clk) begin
        if (mepc_load) begin
            mepc_q <= mepc_next;
        end
    end

    assign mepc_word = {mepc_q, 1'b0};
    assign csr_mepc  = mepc_load ? {mepc_next, 1'b0} : mepc_word;    // Forward during a write

    // mcause
    // ------------------------------------------------------------
    assign mcause_next  = apply_op(mcause_word, op);
    assign mcause_legal = (mcause_next[xlen-1:cause_w] == '0) &&
                          (mcause_next[cause_w-1:0] inside {cause_ialign, cause_iaccess,
                              cause_iopcode, cause_breakpt, cause_ldalign, cause_ldaccess,
                              cause_stalign, cause_staccess, cause_ecallm});

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mcause_int_q  <= 1'b0;
            mcause_code_q <= '0;
        end else if (trap_any) begin
            mcause_int_q  <= trap.intr;
            mcause_code_q <= trap.cause;
        end else if (mcause_we && mcause_legal) begin
            mcause_int_q  <= 1'b0;                                    // Legal codes are all exceptions
            mcause_code_q <= mcause_next[cause_w-1:0];
        end
    end

    assign mcause_word = {mcause_int_q, {(xlen-1-cause_w){1'b0}}, mcause_code_q};

    // mtval
    // ------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (trap.cpu) begin
            mtval_q <= trap.mtval;
        end else if (mtval_we) begin
            mtval_q <= apply_op(mtval_q, op);
        end
    end

    assign mtval_word = mtval_q;

endmodule

// ==== logic/csr_vector_scratch.sv ====
/*
 * Trap vector register mtvec and the mscratch register.
 * Mode values 2 and 3 are rejected, as is a vectored base
 * that is not 128-byte aligned. A rejected write changes nothing.
 */
`timescale 1ns/1ps

module csr_vector_scratch
    import csr_map_pkg::*;
(
    input  logic            g_clk,
    input  logic            g_resetn,
    input  logic            mtvec_we,
    input  logic            mscratch_we,
    input  wr_op_t          op,
    output logic [xlen-1:0] mtvec_word,
    output logic [xlen-1:0] mscratch_word,
    output logic [xlen-1:0] mtvec_base,
    output logic [1:0]      mtvec_mode,
    output logic            mtvec_reject
);

    logic [xlen-1:0] mtvec_q;
    logic [xlen-1:0] mtvec_next;
    logic [xlen-1:0] mscratch_q;
    logic            bad_mode;
    logic            bad_align;

    // mtvec
    // ------------------------------------------------------------
    assign mtvec_next   = apply_op(mtvec_q, op);
    assign bad_mode     = mtvec_next[1];                              // Reserved modes
    assign bad_align    = mtvec_next[0] &&
                          (mtvec_next[$clog2(mtvec_vect_align)-1:2] != '0);
    assign mtvec_reject = bad_mode | bad_align;                       // Top qualifies with the strobe

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mtvec_q <= {mtvec_base_reset[xlen-1:2], mtvec_mode_reset};
        end else if (mtvec_we && !mtvec_reject) begin
            mtvec_q <= mtvec_next;
        end
    end

    assign mtvec_word = mtvec_q;
    assign mtvec_base = {mtvec_q[xlen-1:2], 2'b00};
    assign mtvec_mode = mtvec_q[1:0];

    // mscratch
    // ------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (mscratch_we) begin
            mscratch_q <= apply_op(mscratch_q, op);
        end
    end

    assign mscratch_word = mscratch_q;

endmodule

// ==== logic/machine_csrs.sv ====
/*
 * Machine-mode CSR block of a 64-bit core, one access per cycle.
 * Reads and errors are combinational; writes land on the next edge.
 * A trap and a software write to the same register resolve to the trap.
 * Writes to misa and mip are accepted and ignored.
 */
`timescale 1ns/1ps

module machine_csrs
    import csr_map_pkg::*;
    import csr_trap_pkg::*;
(
    input  logic            g_clk,
    input  logic            g_resetn,
    input  csr_req_t        req,
    input  trap_t           trap,
    input  logic            exec_mret,
    input  irq_lines_t      irq_pend,
    output logic [xlen-1:0] csr_rdata,
    output logic            csr_error,
    output logic [xlen-1:0] csr_mepc,
    output logic [xlen-1:0] mtvec_base,
    output logic [1:0]      mtvec_mode,
    output logic            mstatus_mie,
    output irq_lines_t      irq_en
);

    logic            wr_stb;
    logic            addr_miss;
    wr_op_t          op;
    logic            mstatus_we, mie_we, mtvec_we, mscratch_we;
    logic            mepc_we, mcause_we, mtval_we;
    logic            mtvec_reject;
    logic [xlen-1:0] mstatus_word, mie_word, mip_word;
    logic [xlen-1:0] mepc_word, mcause_word, mtval_word;
    logic [xlen-1:0] mtvec_word, mscratch_word;

    // Write strobes
    // ------------------------------------------------------------
    assign wr_stb      = req.en & req.wr;
    assign op.kind     = req.kind;
    assign op.wdata    = req.wdata;

    assign mstatus_we  = wr_stb && (req.addr == addr_mstatus);
    assign mie_we      = wr_stb && (req.addr == addr_mie);
    assign mtvec_we    = wr_stb && (req.addr == addr_mtvec);
    assign mscratch_we = wr_stb && (req.addr == addr_mscratch);
    assign mepc_we     = wr_stb && (req.addr == addr_mepc);
    assign mcause_we   = wr_stb && (req.addr == addr_mcause);
    assign mtval_we    = wr_stb && (req.addr == addr_mtval);

    csr_status_irq u_status_irq (
        .g_clk, .g_resetn, .mstatus_we, .mie_we, .op, .trap, .exec_mret, .irq_pend,
        .mstatus_word, .mie_word, .mip_word, .mstatus_mie, .irq_en
    );

    csr_trap_record u_trap_record (
        .g_clk, .g_resetn, .mepc_we, .mcause_we, .mtval_we, .op, .trap,
        .mepc_word, .mcause_word, .mtval_word, .csr_mepc
    );

    csr_vector_scratch u_vector_scratch (
        .g_clk, .g_resetn, .mtvec_we, .mscratch_we, .op,
        .mtvec_word, .mscratch_word, .mtvec_base, .mtvec_mode, .mtvec_reject
    );

    // Read select, only decoded while an access is active
    // ------------------------------------------------------------
    always_comb begin
        csr_rdata = '0;
        addr_miss = 1'b0;
        if (req.en) begin
            case (req.addr)
                addr_mstatus:  csr_rdata = mstatus_word;
                addr_misa:     csr_rdata = misa_value;
                addr_mie:      csr_rdata = mie_word;
                addr_mtvec:    csr_rdata = mtvec_word;
                addr_mscratch: csr_rdata = mscratch_word;
                addr_mepc:     csr_rdata = mepc_word;
                addr_mcause:   csr_rdata = mcause_word;
                addr_mtval:    csr_rdata = mtval_word;
                addr_mip:      csr_rdata = mip_word;
                default:       addr_miss = 1'b1;                      // Reads as zero
            endcase
        end
    end

    assign csr_error = wr_stb && (addr_miss || (mtvec_we && mtvec_reject));

endmodule

// ==== verification/tb_clock.sv ====
/*
 * Testbench clock and reset. 4 ns period, reset low for 4 cycles
 * and released on a falling edge.
 */
`timescale 1ns/1ps

module tb_clock (
    output logic g_clk,
    output logic g_resetn
);

    initial begin
        g_clk = 1'b0;
        forever #2 g_clk = ~g_clk;                                    // 4 ns period
    end

    initial begin
        g_resetn = 1'b0;
        repeat (4) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;
    end

endmodule

// ==== verification/csr_scoreboard.sv ====
/*
 * Compares the CSR block outputs with the expected values of each table row.
 * Sampling is on the rising edge that ends the row's cycle.
 * aux_sel 1 checks the mtvec outputs, 2 checks irq_en, 3 checks csr_mepc.
 */
`timescale 1ns/1ps

module csr_scoreboard
    import csr_map_pkg::*;
    import csr_trap_pkg::*;
(
    input  logic            g_clk,
    input  logic            chk_en,
    input  logic            done,
    input  logic [3:0]      grp,
    input  logic            chk_rd,
    input  logic [xlen-1:0] exp_rdata,
    input  logic            exp_err,
    input  logic            exp_mie,
    input  logic [1:0]      aux_sel,
    input  logic [xlen-1:0] exp_aux,
    input  logic [xlen-1:0] csr_rdata,
    input  logic            csr_error,
    input  logic            mstatus_mie,
    input  logic [xlen-1:0] mtvec_base,
    input  logic [1:0]      mtvec_mode,
    input  irq_lines_t      irq_en,
    input  logic [xlen-1:0] csr_mepc,
    output int              err_count,
    output int              check_count
);

    int         errors     = 0;
    int         checks     = 0;
    int         grp_errs   = 0;
    int         grp_checks = 0;
    logic [3:0] cur_grp    = 4'd0;
    logic       started    = 1'b0;
    logic       closed     = 1'b0;

    assign err_count   = errors;
    assign check_count = checks;

    function automatic string group_name(input logic [3:0] g);
        case (g)
            4'd1:    return "reset values";
            4'd2:    return "mscratch operations";
            4'd3:    return "mtvec legality";
            4'd4:    return "trap and mret";
            4'd5:    return "interrupt enable and pending";
            default: return "unknown address and mcause legality";
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [xlen-1:0] got,
                                 input logic [xlen-1:0] exp);
        checks++;
        grp_checks++;
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            errors++;
            grp_errs++;
        end
    endtask

    task automatic report_group();
        $display("test %0d (%s): %s, %0d checks, %0d failed", cur_grp, group_name(cur_grp),
                 (grp_errs == 0) ? "pass" : "FAIL", grp_checks, grp_errs);
        grp_errs   = 0;
        grp_checks = 0;
    endtask

    // Row checks
    // ------------------------------------------------------------
    always @(posedge g_clk) begin
        if (chk_en) begin
            if (started && grp != cur_grp) begin
                report_group();
            end
            cur_grp = grp;
            started = 1'b1;
            if (chk_rd) begin
                compare_value("csr_rdata", csr_rdata, exp_rdata);
            end
            compare_value("csr_error", {63'b0, csr_error}, {63'b0, exp_err});
            compare_value("mstatus_mie", {63'b0, mstatus_mie}, {63'b0, exp_mie});
            if (aux_sel == 2'd1) begin
                compare_value("mtvec_base", mtvec_base, {exp_aux[xlen-1:2], 2'b00});
                compare_value("mtvec_mode", {62'b0, mtvec_mode}, {62'b0, exp_aux[1:0]});
            end else if (aux_sel == 2'd2) begin
                compare_value("irq_en", {61'b0, irq_en}, {61'b0, exp_aux[2:0]});
            end else if (aux_sel == 2'd3) begin
                compare_value("csr_mepc", csr_mepc, exp_aux);
            end
        end else if (done && started && !closed) begin
            report_group();                                           // Last group
            closed = 1'b1;
        end
    end

endmodule

// ==== verification/machine_csrs_chk.sv ====
/*
 * Concurrent checks on the CSR block, bound into machine_csrs.
 * fail_count holds the number of failed assertions.
 */
`timescale 1ns/1ps

module machine_csrs_chk
    import csr_map_pkg::*;
    import csr_trap_pkg::*;
(
    input logic            g_clk,
    input logic            g_resetn,
    input csr_req_t        req,
    input trap_t           trap,
    input logic            csr_error,
    input logic            mstatus_mie,
    input logic [xlen-1:0] csr_mepc
);

    int fail_count = 0;

    a_err_needs_access: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !req.en |-> !csr_error)
        else begin
            $error("csr_error high while no access is active");
            fail_count++;
        end

    a_trap_clears_mie: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (trap.cpu || trap.intr) |=> !mstatus_mie)
        else begin
            $error("mstatus_mie still set one cycle after a trap");
            fail_count++;
        end

    a_mepc_even_pc: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (trap.cpu || trap.intr) |-> (csr_mepc == {trap.pc[xlen-1:1], 1'b0}))
        else begin
            $error("csr_mepc is not the trap pc with bit 0 cleared");
            fail_count++;
        end

endmodule

bind machine_csrs machine_csrs_chk u_chk (.*);

// ==== verification/machine_csrs_tb.sv ====
/*
 * Testbench top for the machine-mode CSR block. One table row per cycle,
 * driven on the falling edge and checked by the scoreboard on the rising edge.
 * mscratch data comes from a 64-bit xorshift with a fixed seed.
 */
`timescale 1ns/1ps

module machine_csrs_tb
    import csr_map_pkg::*;
    import csr_trap_pkg::*;
();

    typedef struct packed {
        logic [3:0]      grp;                                         // Test group
        csr_req_t        req;
        trap_t           trap;
        logic            mret;
        irq_lines_t      pend;
        logic            chk_rd;                                      // Compare csr_rdata
        logic [xlen-1:0] exp_rdata;
        logic            exp_err;
        logic            exp_mie;
        logic [1:0]      aux_sel;
        logic [xlen-1:0] exp_aux;
    } row_t;

    logic            g_clk;
    logic            g_resetn;
    csr_req_t        req;
    trap_t           trap;
    logic            exec_mret;
    irq_lines_t      irq_pend;
    logic [xlen-1:0] csr_rdata;
    logic            csr_error;
    logic [xlen-1:0] csr_mepc;
    logic [xlen-1:0] mtvec_base;
    logic [1:0]      mtvec_mode;
    logic            mstatus_mie;
    irq_lines_t      irq_en;

    logic            chk_en;
    logic            done;
    logic [3:0]      grp;
    logic            chk_rd;
    logic [xlen-1:0] exp_rdata;
    logic            exp_err;
    logic            exp_mie;
    logic [1:0]      aux_sel;
    logic [xlen-1:0] exp_aux;
    int              sb_errors;
    int              sb_checks;

    row_t            rows[$];
    logic [xlen-1:0] rng_state = 64'd44994;
    int              cycles    = 0;
    int              limit     = 1000;                                // Replaced once the table exists

    tb_clock u_tb_clock (.g_clk, .g_resetn);

    machine_csrs u_machine_csrs (
        .g_clk, .g_resetn, .req, .trap, .exec_mret, .irq_pend,
        .csr_rdata, .csr_error, .csr_mepc, .mtvec_base, .mtvec_mode, .mstatus_mie, .irq_en
    );

    csr_scoreboard u_scoreboard (
        .g_clk, .chk_en, .done, .grp, .chk_rd, .exp_rdata, .exp_err, .exp_mie, .aux_sel,
        .exp_aux, .csr_rdata, .csr_error, .mstatus_mie, .mtvec_base, .mtvec_mode, .irq_en,
        .csr_mepc, .err_count(sb_errors), .check_count(sb_checks)
    );

    function automatic logic [xlen-1:0] xorshift64();
        logic [xlen-1:0] x;
        x         = rng_state;
        x         = x ^ (x << 13);
        x         = x ^ (x >> 7);
        x         = x ^ (x << 17);
        rng_state = x;
        return x;
    endfunction

    // Row builders
    // ------------------------------------------------------------
    function automatic row_t idle_row(input logic [3:0] g, input logic mie);
        row_t r;
        r         = '0;
        r.grp     = g;
        r.chk_rd  = 1'b1;                                             // Idle reads back zero
        r.exp_mie = mie;
        return r;
    endfunction

    function automatic row_t read_row(input logic [3:0] g, input logic [addr_w-1:0] a,
                                      input logic [xlen-1:0] exp, input logic mie);
        row_t r;
        r           = idle_row(g, mie);
        r.req.en    = 1'b1;
        r.req.addr  = a;
        r.exp_rdata = exp;
        return r;
    endfunction

    function automatic row_t write_row(input logic [3:0] g, input wr_kind_t k,
                                       input logic [addr_w-1:0] a, input logic [xlen-1:0] d,
                                       input logic err, input logic mie);
        row_t r;
        r           = idle_row(g, mie);
        r.req.en    = 1'b1;
        r.req.wr    = 1'b1;
        r.req.kind  = k;
        r.req.addr  = a;
        r.req.wdata = d;
        r.chk_rd    = 1'b0;
        r.exp_err   = err;
        return r;
    endfunction

    function automatic row_t with_aux(input row_t r, input logic [1:0] sel,
                                      input logic [xlen-1:0] v);
        row_t o;
        o         = r;
        o.aux_sel = sel;
        o.exp_aux = v;
        return o;
    endfunction

    task automatic build_table();
        row_t            r;
        logic [xlen-1:0] r1;
        logic [xlen-1:0] r2;
        logic [xlen-1:0] r3;
        r1 = xorshift64();
        r2 = xorshift64();
        r3 = xorshift64();
        rows.push_back(read_row(4'd1, addr_mstatus, 64'd0, 1'b0));
        rows.push_back(with_aux(read_row(4'd1, addr_mtvec, 64'hC000_0000, 1'b0), 2'd1,
                                64'hC000_0000));
        rows.push_back(read_row(4'd1, addr_mie, 64'd0, 1'b0));
        rows.push_back(read_row(4'd1, addr_misa, 64'h8000_0000_0000_1104, 1'b0));
        rows.push_back(idle_row(4'd1, 1'b0));
        rows.push_back(write_row(4'd2, wr_write, addr_mscratch, r1, 1'b0, 1'b0));
        rows.push_back(read_row(4'd2, addr_mscratch, r1, 1'b0));
        rows.push_back(write_row(4'd2, wr_set, addr_mscratch, r2, 1'b0, 1'b0));
        rows.push_back(read_row(4'd2, addr_mscratch, r1 | r2, 1'b0));
        rows.push_back(write_row(4'd2, wr_clear, addr_mscratch, r3, 1'b0, 1'b0));
        rows.push_back(read_row(4'd2, addr_mscratch, (r1 | r2) & ~r3, 1'b0));
        rows.push_back(write_row(4'd3, wr_write, addr_mtvec, 64'h8000_0002, 1'b1, 1'b0));
        rows.push_back(read_row(4'd3, addr_mtvec, 64'hC000_0000, 1'b0));
        rows.push_back(write_row(4'd3, wr_write, addr_mtvec, 64'h8000_0041, 1'b1, 1'b0));
        rows.push_back(read_row(4'd3, addr_mtvec, 64'hC000_0000, 1'b0));
        rows.push_back(write_row(4'd3, wr_write, addr_mtvec, 64'h8000_0081, 1'b0, 1'b0));
        rows.push_back(with_aux(read_row(4'd3, addr_mtvec, 64'h8000_0081, 1'b0), 2'd1,
                                64'h8000_0081));
        rows.push_back(write_row(4'd4, wr_set, addr_mstatus, 64'h8, 1'b0, 1'b0));
        rows.push_back(read_row(4'd4, addr_mstatus, 64'h8, 1'b1));
        r            = idle_row(4'd4, 1'b1);                          // CPU trap, odd pc
        r.trap.cpu   = 1'b1;
        r.trap.cause = 7'd2;
        r.trap.mtval = 64'hDEAD_BEEF;
        r.trap.pc    = 64'h8000_1235;
        rows.push_back(with_aux(r, 2'd3, 64'h8000_1234));
        rows.push_back(with_aux(read_row(4'd4, addr_mepc, 64'h8000_1234, 1'b0), 2'd3,
                                64'h8000_1234));
        rows.push_back(read_row(4'd4, addr_mcause, 64'd2, 1'b0));
        rows.push_back(read_row(4'd4, addr_mtval, 64'hDEAD_BEEF, 1'b0));
        rows.push_back(read_row(4'd4, addr_mstatus, 64'h80, 1'b0));
        r      = idle_row(4'd4, 1'b0);
        r.mret = 1'b1;
        rows.push_back(r);
        rows.push_back(read_row(4'd4, addr_mstatus, 64'h8, 1'b1));
        r            = idle_row(4'd4, 1'b1);                          // Timer interrupt
        r.trap.intr  = 1'b1;
        r.trap.cause = 7'd7;
        r.trap.mtval = 64'h1111;
        r.trap.pc    = 64'h8000_2000;
        rows.push_back(with_aux(r, 2'd3, 64'h8000_2000));
        rows.push_back(read_row(4'd4, addr_mcause, 64'h8000_0000_0000_0007, 1'b0));
        rows.push_back(read_row(4'd4, addr_mtval, 64'hDEAD_BEEF, 1'b0));
        rows.push_back(with_aux(write_row(4'd4, wr_write, addr_mepc, 64'h8000_3001, 1'b0,
                                          1'b0), 2'd3, 64'h8000_3000));
        rows.push_back(write_row(4'd5, wr_write, addr_mie, 64'h888, 1'b0, 1'b0));
        rows.push_back(with_aux(read_row(4'd5, addr_mie, 64'h888, 1'b0), 2'd2, 64'b111));
        rows.push_back(write_row(4'd5, wr_clear, addr_mie, 64'h080, 1'b0, 1'b0));
        rows.push_back(with_aux(read_row(4'd5, addr_mie, 64'h808, 1'b0), 2'd2, 64'b101));
        r      = read_row(4'd5, addr_mip, 64'h088, 1'b0);
        r.pend = 3'b011;
        rows.push_back(r);
        r      = read_row(4'd5, addr_mip, 64'h800, 1'b0);
        r.pend = 3'b100;
        rows.push_back(r);
        rows.push_back(write_row(4'd6, wr_write, 12'h7C0, 64'h5, 1'b1, 1'b0));
        rows.push_back(read_row(4'd6, 12'h7C0, 64'd0, 1'b0));
        rows.push_back(write_row(4'd6, wr_write, addr_mcause, 64'd10, 1'b0, 1'b0));
        rows.push_back(read_row(4'd6, addr_mcause, 64'h8000_0000_0000_0007, 1'b0));
        rows.push_back(write_row(4'd6, wr_write, addr_mcause, 64'd11, 1'b0, 1'b0));
        rows.push_back(read_row(4'd6, addr_mcause, 64'd11, 1'b0));
    endtask

    task automatic apply_row(input row_t r);
        req       = r.req;
        trap      = r.trap;
        exec_mret = r.mret;
        irq_pend  = r.pend;
        grp       = r.grp;
        chk_rd    = r.chk_rd;
        exp_rdata = r.exp_rdata;
        exp_err   = r.exp_err;
        exp_mie   = r.exp_mie;
        aux_sel   = r.aux_sel;
        exp_aux   = r.exp_aux;
        chk_en    = 1'b1;
    endtask

    // Stimulus
    // ------------------------------------------------------------
    initial begin
        req       = '0;
        trap      = '0;
        exec_mret = 1'b0;
        irq_pend  = '0;
        chk_en    = 1'b0;
        done      = 1'b0;
        grp       = 4'd0;
        chk_rd    = 1'b0;
        exp_rdata = '0;
        exp_err   = 1'b0;
        exp_mie   = 1'b0;
        aux_sel   = 2'd0;
        exp_aux   = '0;
        build_table();
        limit = rows.size() + 4 + 20;                                 // Rows, reset, margin
        wait (g_resetn === 1'b1);
        foreach (rows[i]) begin
            @(negedge g_clk);
            apply_row(rows[i]);
        end
        @(negedge g_clk);
        req       = '0;
        trap      = '0;
        exec_mret = 1'b0;
        chk_en    = 1'b0;
        done      = 1'b1;
        @(posedge g_clk);
        @(negedge g_clk);
        $display("%0d checks, %0d mismatches, %0d assertion failures",
                 sb_checks, sb_errors, u_machine_csrs.u_chk.fail_count);
        if (sb_errors == 0 && u_machine_csrs.u_chk.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    always @(posedge g_clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Run timed out: the table did not finish within %0d cycles", limit);
            $display("Errors found");
            $finish;
        end
    end

endmodule

// ==== sources.f ====
logic/csr_map_pkg.sv
logic/csr_trap_pkg.sv
logic/csr_status_irq.sv
logic/csr_trap_record.sv
logic/csr_vector_scratch.sv
logic/machine_csrs.sv
verification/tb_clock.sv
verification/csr_scoreboard.sv
verification/machine_csrs_chk.sv
verification/machine_csrs_tb.sv

// ==== Makefile ====
TOP := machine_csrs_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f sources.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "No errors"

clean:
	rm -rf obj_dir
